// ==== hdl/mmc_ro_pkg.sv ====
`default_nettype none

package mmc_ro_pkg;

  typedef logic [7:0]  mmc_byte_t;
  typedef logic [31:0] cmd_arg_t;
  typedef logic [6:0]  crc7_t;

  localparam int CLK_DIV        = 4;   // clk cycles per MMC clock.
  localparam int INIT_CYCLES    = 74;
  localparam int BLOCK_LEN      = 512;
  localparam int BOOT_BLOCKS    = 2;
  localparam int CMD_FRAME_BITS = 48;
  localparam int CMD_CRC_BITS   = CMD_FRAME_BITS - 8; // Start, tx, index, arg.
  localparam int CMD_GAP_CYCLES = 8;   // Idle clocks between the two CMD0s.

  localparam logic [5:0] CMD_GO_IDLE = 6'd0;
  localparam cmd_arg_t   ARG_BOOT    = 32'hFFFFFFFA;
  localparam crc7_t      CRC7_POLY   = 7'h09;    // x^7 + x^3 + 1.
  localparam mmc_byte_t  DATA_START  = 8'h00;
  localparam mmc_byte_t  DATA_END    = 8'hFF;

  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_AFULL = 12;

  localparam int DIV_W      = $clog2(CLK_DIV);
  localparam int SEQ_CNT_W  = $clog2(INIT_CYCLES);
  localparam int BLK_CNT_W  = $clog2(BOOT_BLOCKS + 1);
  localparam int BYTE_CNT_W = $clog2(BLOCK_LEN);
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

  typedef enum logic [2:0] {
    SEQ_INIT, SEQ_CMD_IDLE, SEQ_CMD_BOOT, SEQ_STREAM, SEQ_CMD_END, SEQ_DONE
  } seq_state_t;

  typedef enum logic [1:0] {RX_WAIT_START, RX_DATA, RX_END} rx_state_t;

endpackage

`default_nettype wire

// ==== hdl/mmc_cmd_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmc_cmd_seq (
  input  wire  clk,
  input  wire  arst_n,
  input  wire  afull,
  input  wire  block_done,
  output logic mmc_clk,
  output logic mmc_cmd_o,
  output logic mmc_cmd_oen,
  output logic sample_en,
  output logic stream_en
);

  mmc_ro_pkg::seq_state_t                   state;
  mmc_ro_pkg::seq_state_t                   next_state;
  logic [mmc_ro_pkg::DIV_W-1:0]             div_cnt;
  logic [mmc_ro_pkg::SEQ_CNT_W-1:0]         cnt;     // Idle clocks or frame bit index.
  logic [mmc_ro_pkg::BLK_CNT_W-1:0]         blk_cnt;
  logic [mmc_ro_pkg::CMD_CRC_BITS-1:0]      shreg;
  mmc_ro_pkg::crc7_t                        crc;
  mmc_ro_pkg::crc7_t                        crc_step;
  mmc_ro_pkg::cmd_arg_t                     load_arg;
  logic                                     load;
  logic                                     frame_act;
  logic                                     frame_end;
  logic                                     cmd_bit;
  logic                                     run;
  logic                                     rise;
  logic                                     fall;

  // Rising edge waits at the end of the low phase while the FIFO is nearly full.
  assign run       = (state != mmc_ro_pkg::SEQ_DONE);
  assign rise      = run && !afull && (div_cnt == mmc_ro_pkg::DIV_W'(mmc_ro_pkg::CLK_DIV - 1));
  assign fall      = (div_cnt == mmc_ro_pkg::DIV_W'(mmc_ro_pkg::CLK_DIV / 2 - 1));
  assign sample_en = rise;
  assign stream_en = (state == mmc_ro_pkg::SEQ_STREAM);
  assign frame_end = fall && (cnt == mmc_ro_pkg::SEQ_CNT_W'(mmc_ro_pkg::CMD_FRAME_BITS - 1));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      div_cnt <= mmc_ro_pkg::DIV_W'(mmc_ro_pkg::CLK_DIV - 1); // First rise right away.
      mmc_clk <= 1'b0;
    end else if (rise) begin
      div_cnt <= '0;
      mmc_clk <= 1'b1;
    end else if (div_cnt != mmc_ro_pkg::DIV_W'(mmc_ro_pkg::CLK_DIV - 1)) begin
      div_cnt <= div_cnt + 1'b1;
      if (fall) mmc_clk <= 1'b0;
    end
  end

  // Serial CRC7 over the bit now on the line.
  assign crc_step = {crc[5:0], 1'b0} ^
                    ((shreg[mmc_ro_pkg::CMD_CRC_BITS-1] ^ crc[6]) ? mmc_ro_pkg::CRC7_POLY : '0);

  always_comb begin
    if (cnt < mmc_ro_pkg::SEQ_CNT_W'(mmc_ro_pkg::CMD_CRC_BITS)) begin
      cmd_bit = shreg[mmc_ro_pkg::CMD_CRC_BITS-1];
    end else if (cnt < mmc_ro_pkg::SEQ_CNT_W'(mmc_ro_pkg::CMD_FRAME_BITS - 1)) begin
      cmd_bit = crc[6];
    end else begin
      cmd_bit = 1'b1; // End bit.
    end
  end

  assign mmc_cmd_o   = frame_act ? cmd_bit : 1'b1;
  assign mmc_cmd_oen = !frame_act;

  // Steps once per MMC clock, on the falling edge.
  always_comb begin
    next_state = state;
    load       = 1'b0;
    load_arg   = '0;
    if (fall) begin
      case (state)
        mmc_ro_pkg::SEQ_INIT:
          if (cnt == mmc_ro_pkg::SEQ_CNT_W'(mmc_ro_pkg::INIT_CYCLES - 1)) begin
            load       = 1'b1;
            next_state = mmc_ro_pkg::SEQ_CMD_IDLE;
          end
        mmc_ro_pkg::SEQ_CMD_IDLE:
          if (cnt == mmc_ro_pkg::SEQ_CNT_W'(mmc_ro_pkg::CMD_FRAME_BITS +
                                            mmc_ro_pkg::CMD_GAP_CYCLES - 1)) begin
            load       = 1'b1;
            load_arg   = mmc_ro_pkg::ARG_BOOT;
            next_state = mmc_ro_pkg::SEQ_CMD_BOOT;
          end
        mmc_ro_pkg::SEQ_CMD_BOOT:
          if (frame_end) next_state = mmc_ro_pkg::SEQ_STREAM;
        mmc_ro_pkg::SEQ_STREAM:
          if (blk_cnt == mmc_ro_pkg::BLK_CNT_W'(mmc_ro_pkg::BOOT_BLOCKS)) begin
            load       = 1'b1; // Closing CMD0 ends the boot.
            next_state = mmc_ro_pkg::SEQ_CMD_END;
          end
        mmc_ro_pkg::SEQ_CMD_END:
          if (frame_end) next_state = mmc_ro_pkg::SEQ_DONE;
        default: next_state = state;
      endcase
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= mmc_ro_pkg::SEQ_INIT;
      cnt       <= '0;
      blk_cnt   <= '0;
      frame_act <= 1'b0;
      crc       <= '0;
    end else begin
      state <= next_state;
      if (block_done && blk_cnt != mmc_ro_pkg::BLK_CNT_W'(mmc_ro_pkg::BOOT_BLOCKS)) begin
        blk_cnt <= blk_cnt + 1'b1;
      end
      if (load) begin
        cnt       <= '0;
        crc       <= '0;
        frame_act <= 1'b1;
      end else if (fall) begin
        cnt <= cnt + 1'b1;
        if (frame_end) frame_act <= 1'b0;
        if (frame_act) begin
          crc <= (cnt < mmc_ro_pkg::SEQ_CNT_W'(mmc_ro_pkg::CMD_CRC_BITS)) ? crc_step
                                                                          : {crc[5:0], 1'b0};
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      shreg <= {1'b0, 1'b1, mmc_ro_pkg::CMD_GO_IDLE, load_arg};
    end else if (fall && frame_act) begin
      shreg <= shreg << 1;
    end
  end

  // Card must see no edge while the buffer is close to full.
  a_no_sample_afull: assert property (@(posedge clk) disable iff (!arst_n)
    afull |-> !sample_en ##1 !$rose(mmc_clk));

  // Command line only moves with the falling edge.
  a_cmd_on_fall: assert property (@(posedge clk) disable iff (!arst_n)
    $changed(mmc_cmd_o) |-> !mmc_clk);

endmodule

`default_nettype wire

// ==== hdl/mmc_data_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmc_data_rx (
  input  wire                   clk,
  input  wire                   arst_n,
  input  wire                   sample_en,
  input  wire                   stream_en,
  input  wire mmc_ro_pkg::mmc_byte_t mmc_data_i,
  output logic                  rx_valid,
  output mmc_ro_pkg::mmc_byte_t rx_byte,
  output logic                  block_done,
  output logic                  frame_err
);

  mmc_ro_pkg::rx_state_t               state;
  logic [mmc_ro_pkg::BYTE_CNT_W-1:0]   byte_cnt;
  logic                                take;
  logic                                last_byte;

  assign take      = stream_en && sample_en;
  assign last_byte = (byte_cnt == mmc_ro_pkg::BYTE_CNT_W'(mmc_ro_pkg::BLOCK_LEN - 1));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= mmc_ro_pkg::RX_WAIT_START;
      byte_cnt   <= '0;
      rx_valid   <= 1'b0;
      block_done <= 1'b0;
      frame_err  <= 1'b0;
    end else begin
      rx_valid   <= 1'b0;
      block_done <= 1'b0;
      if (!stream_en) begin
        state <= mmc_ro_pkg::RX_WAIT_START; // Outside the boot window.
      end else if (take) begin
        case (state)
          mmc_ro_pkg::RX_WAIT_START: begin
            // Anything but the token is idle bus.
            if (mmc_data_i == mmc_ro_pkg::DATA_START) begin
              state    <= mmc_ro_pkg::RX_DATA;
              byte_cnt <= '0;
            end
          end
          mmc_ro_pkg::RX_DATA: begin
            rx_valid <= 1'b1;
            byte_cnt <= byte_cnt + 1'b1;
            if (last_byte) state <= mmc_ro_pkg::RX_END;
          end
          mmc_ro_pkg::RX_END: begin
            block_done <= 1'b1;
            if (mmc_data_i != mmc_ro_pkg::DATA_END) begin
              frame_err <= 1'b1; // Sticky until reset.
            end
            state <= mmc_ro_pkg::RX_WAIT_START;
          end
          default: state <= mmc_ro_pkg::RX_WAIT_START;
        endcase
      end
    end
  end

  // Byte lands with rx_valid one cycle after the sample.
  always_ff @(posedge clk) begin
    if (take && state == mmc_ro_pkg::RX_DATA) begin
      rx_byte <= mmc_data_i;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/byte_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_fifo (
  input  wire                   clk,
  input  wire                   arst_n,
  input  wire                   wr_en,
  input  wire mmc_ro_pkg::mmc_byte_t wr_data,
  input  wire                   rd_en,
  output mmc_ro_pkg::mmc_byte_t rd_data,
  output logic                  empty,
  output logic                  afull
);

  mmc_ro_pkg::mmc_byte_t             mem [mmc_ro_pkg::FIFO_DEPTH];
  logic [mmc_ro_pkg::FIFO_AW-1:0]    wr_ptr;
  logic [mmc_ro_pkg::FIFO_AW-1:0]    rd_ptr;
  logic [mmc_ro_pkg::FIFO_AW:0]      count;
  logic                              full;

  assign empty = (count == '0);
  assign full  = (count == (mmc_ro_pkg::FIFO_AW + 1)'(mmc_ro_pkg::FIFO_DEPTH));
  assign afull = (count >= (mmc_ro_pkg::FIFO_AW + 1)'(mmc_ro_pkg::FIFO_AFULL));

  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_ptr] <= wr_data;
    if (rd_en) rd_data <= mem[rd_ptr]; // Registered read.
  end

  // Pointers wrap on their own, depth is a power of two.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // The MMC stall upstream keeps this from filling.
  a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
    wr_en |-> !full);

  a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
    rd_en |-> !empty);

endmodule

`default_nettype wire

// ==== hdl/user_stream_out.sv ====
`timescale 1ns/1ps
`default_nettype none

module user_stream_out (
  input  wire                   clk,
  input  wire                   arst_n,
  input  wire                   empty,
  input  wire mmc_ro_pkg::mmc_byte_t rd_data,
  input  wire                   user_rdy,
  output logic                  rd_en,
  output mmc_ro_pkg::mmc_byte_t user_data_o,
  output logic                  user_data_strb
);

  // Pop only while the user can take the byte next cycle.
  assign rd_en = user_rdy && !empty;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      user_data_strb <= 1'b0;
    end else begin
      user_data_strb <= rd_en; // Lines up with the FIFO read register.
    end
  end

  // Bus idles at zero between strobes.
  assign user_data_o = user_data_strb ? rd_data : '0;

  a_strb_after_rdy: assert property (@(posedge clk) disable iff (!arst_n)
    user_data_strb |-> $past(user_rdy) && $past(!empty));

endmodule

`default_nettype wire

// ==== hdl/mmc_ro.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmc_ro (
  input  wire                   clk,
  input  wire                   arst_n,
  input  wire                   mmc_cmd_i,  // No responses expected.
  input  wire mmc_ro_pkg::mmc_byte_t mmc_data_i,
  input  wire                   user_rdy,
  output logic                  mmc_clk,
  output logic                  mmc_cmd_o,
  output logic                  mmc_cmd_oen,
  output mmc_ro_pkg::mmc_byte_t user_data_o,
  output logic                  user_data_strb,
  output logic                  frame_err
);

  logic                  afull;
  logic                  empty;
  logic                  block_done;
  logic                  sample_en;
  logic                  stream_en;
  logic                  rx_valid;
  logic                  rd_en;
  mmc_ro_pkg::mmc_byte_t rx_byte;
  mmc_ro_pkg::mmc_byte_t rd_data;

  mmc_cmd_seq u_cmd_seq (
    .clk         (clk),
    .arst_n      (arst_n),
    .afull       (afull),
    .block_done  (block_done),
    .mmc_clk     (mmc_clk),
    .mmc_cmd_o   (mmc_cmd_o),
    .mmc_cmd_oen (mmc_cmd_oen),
    .sample_en   (sample_en),
    .stream_en   (stream_en)
  );

  mmc_data_rx u_data_rx (
    .clk        (clk),
    .arst_n     (arst_n),
    .sample_en  (sample_en),
    .stream_en  (stream_en),
    .mmc_data_i (mmc_data_i),
    .rx_valid   (rx_valid),
    .rx_byte    (rx_byte),
    .block_done (block_done),
    .frame_err  (frame_err)
  );

  byte_fifo u_fifo (
    .clk     (clk),
    .arst_n  (arst_n),
    .wr_en   (rx_valid),
    .wr_data (rx_byte),
    .rd_en   (rd_en),
    .rd_data (rd_data),
    .empty   (empty),
    .afull   (afull)
  );

  user_stream_out u_stream_out (
    .clk            (clk),
    .arst_n         (arst_n),
    .empty          (empty),
    .rd_data        (rd_data),
    .user_rdy       (user_rdy),
    .rd_en          (rd_en),
    .user_data_o    (user_data_o),
    .user_data_strb (user_data_strb)
  );

endmodule

`default_nettype wire

// ==== tests/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk
);

  localparam int HALF_PERIOD_NS = 50; // 100 ns period.

  initial begin
    clk = 1'b0;
    forever begin
      #(HALF_PERIOD_NS) clk = ~clk;
    end
  end

endmodule

`default_nettype wire

// ==== tests/mmc_card_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmc_card_model (
  input  wire         rst_n,
  input  wire         mmc_clk,
  input  wire         mmc_cmd,
  input  wire         mmc_cmd_oen,
  input  wire         corrupt_end,  // Bad end sample on block 1.
  output logic [7:0]  mmc_data,
  output logic [7:0]  frame_cnt,    // Running count of decoded frames.
  output logic [47:0] frame_bits    // Last decoded frame.
);

  localparam logic [15:0] SEED     = 16'd4748;
  localparam int          GAP_CLKS = 2; // Idle bus ahead of each token.
  localparam int          END_POS  = GAP_CLKS + mmc_ro_pkg::BLOCK_LEN + 1;

  logic [15:0] data_lfsr = SEED; // Keeps running across boots.
  logic [47:0] shift_in  = '0;
  logic [47:0] frame_now;
  logic [7:0]  next_byte;
  logic        boot_req  = 1'b0;
  int          bit_cnt   = 0;
  int          blk       = 0;
  int          pos       = 0;

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  initial begin
    mmc_data   = 8'hFF;
    frame_cnt  = '0;
    frame_bits = '0;
  end

  // Host moves CMD after the falling edge, so it is stable here.
  always @(posedge mmc_clk or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt  <= 0;
      boot_req <= 1'b0;
    end else if (bit_cnt != 0 || (!mmc_cmd_oen && !mmc_cmd)) begin
      frame_now = {shift_in[46:0], mmc_cmd};
      shift_in <= frame_now;
      if (bit_cnt == 47) begin
        bit_cnt    <= 0;
        frame_bits <= frame_now;
        frame_cnt  <= frame_cnt + 8'd1;
        if (frame_now[45:40] == 6'd0 && frame_now[39:8] == mmc_ro_pkg::ARG_BOOT) begin
          boot_req <= 1'b1; // Alternative boot.
        end
      end else begin
        bit_cnt <= bit_cnt + 1;
      end
    end
  end

  // Gap, token, block bytes, end sample, per block.
  always @(negedge mmc_clk or negedge rst_n) begin
    if (!rst_n) begin
      blk      <= 0;
      pos      <= 0;
      mmc_data <= 8'hFF;
    end else if (boot_req && blk < mmc_ro_pkg::BOOT_BLOCKS) begin
      if (pos < GAP_CLKS) begin
        mmc_data <= 8'hFF;
      end else if (pos == GAP_CLKS) begin
        mmc_data <= 8'h00;
      end else if (pos < END_POS) begin
        for (int i = 0; i < 8; i++) begin
          data_lfsr = lfsr_step(data_lfsr);
          next_byte = {next_byte[6:0], data_lfsr[0]};
        end
        mmc_data <= next_byte;
      end else begin
        mmc_data <= (corrupt_end && blk == 1) ? 8'hFE : 8'hFF;
      end
      if (pos == END_POS) begin
        pos <= 0;
        blk <= blk + 1;
      end else begin
        pos <= pos + 1;
      end
    end else begin
      mmc_data <= 8'hFF;
    end
  end

endmodule

`default_nettype wire

// ==== tests/tb_mmc_ro.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mmc_ro;

  localparam logic [15:0] SEED       = 16'd4748;
  localparam int          BOOT_BYTES = mmc_ro_pkg::BOOT_BLOCKS * mmc_ro_pkg::BLOCK_LEN;
  // Boot length in clk cycles, times 4 for stalls.
  localparam int BOOT_EST = (mmc_ro_pkg::INIT_CYCLES + 3 * mmc_ro_pkg::CMD_FRAME_BITS +
                             mmc_ro_pkg::BOOT_BLOCKS * (mmc_ro_pkg::BLOCK_LEN + 2)) *
                            mmc_ro_pkg::CLK_DIV * 4;
  localparam int WATCHDOG_CYCLES = 2 * 2 * BOOT_EST; // Two boots, twice the estimate.

  logic                  clk;
  logic                  arst_n;
  logic                  mmc_cmd_i   = 1'b1; // Card responses are not modeled.
  logic                  user_rdy    = 1'b0;
  logic                  corrupt_end = 1'b0;
  logic                  mmc_clk;
  logic                  mmc_cmd_o;
  logic                  mmc_cmd_oen;
  mmc_ro_pkg::mmc_byte_t mmc_data;
  mmc_ro_pkg::mmc_byte_t user_data_o;
  logic                  user_data_strb;
  logic                  frame_err;
  logic [7:0]            frame_cnt;
  logic [47:0]           frame_bits;

  mmc_ro_pkg::mmc_byte_t exp_q[$];
  mmc_ro_pkg::mmc_byte_t exp_byte;
  logic [15:0]           rdy_lfsr    = SEED;
  logic [15:0]           ref_lfsr    = SEED; // Mirrors the card's byte source.
  logic                  last_rdy    = 1'b0;
  logic                  err_seen    = 1'b0;
  int                    frames_seen = 0;
  int                    rx_cnt      = 0;
  int                    data_errs   = 0;
  int                    hs_errs     = 0;
  int                    frame_errs  = 0;
  int                    flag_errs   = 0;
  int                    end_errs    = 0;

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // x^7 + x^3 + 1, MSB first.
  function automatic mmc_ro_pkg::crc7_t crc7_of(input logic [39:0] bits);
    mmc_ro_pkg::crc7_t crc;
    logic              fb;
    crc = '0;
    for (int i = 39; i >= 0; i--) begin
      fb  = bits[i] ^ crc[6];
      crc = {crc[5:0], 1'b0};
      if (fb) crc = crc ^ 7'h09;
    end
    return crc;
  endfunction

  task automatic push_boot_bytes();
    mmc_ro_pkg::mmc_byte_t b;
    b = '0;
    for (int n = 0; n < BOOT_BYTES; n++) begin
      for (int i = 0; i < 8; i++) begin
        ref_lfsr = lfsr_step(ref_lfsr);
        b = {b[6:0], ref_lfsr[0]};
      end
      exp_q.push_back(b);
    end
  endtask

  task automatic check_frame(input logic [47:0] f, input int idx);
    mmc_ro_pkg::cmd_arg_t exp_arg;
    mmc_ro_pkg::crc7_t    exp_crc;
    exp_arg = (idx == 1) ? mmc_ro_pkg::ARG_BOOT : '0;
    exp_crc = crc7_of({1'b0, 1'b1, 6'd0, exp_arg});
    if (f[47] !== 1'b0 || f[46] !== 1'b1 || f[0] !== 1'b1) begin
      $display("[ERROR] %0t mmc_cmd_o frame %0d start/tx/end: got %b%b%b expected 011",
               $time, idx, f[47], f[46], f[0]);
      frame_errs++;
    end
    if (f[45:40] !== 6'd0) begin
      $display("[ERROR] %0t mmc_cmd_o frame %0d index: got %0d expected 0",
               $time, idx, f[45:40]);
      frame_errs++;
    end
    if (f[39:8] !== exp_arg) begin
      $display("[ERROR] %0t mmc_cmd_o frame %0d argument: got %08h expected %08h",
               $time, idx, f[39:8], exp_arg);
      frame_errs++;
    end
    if (f[7:1] !== exp_crc) begin
      $display("[ERROR] %0t mmc_cmd_o frame %0d crc7: got %02h expected %02h",
               $time, idx, f[7:1], exp_crc);
      frame_errs++;
    end
  endtask

  task automatic check_reset_values();
    if (mmc_clk !== 1'b0 || mmc_cmd_oen !== 1'b1 || mmc_cmd_o !== 1'b1) begin
      $display("[ERROR] %0t mmc_clk/mmc_cmd_oen/mmc_cmd_o: got %b%b%b expected 011",
               $time, mmc_clk, mmc_cmd_oen, mmc_cmd_o);
      end_errs++;
    end
    if (user_data_strb !== 1'b0 || frame_err !== 1'b0) begin
      $display("[ERROR] %0t user_data_strb/frame_err: got %b%b expected 00",
               $time, user_data_strb, frame_err);
      end_errs++;
    end
  endtask

  task automatic run_boot(input int boot);
    corrupt_end <= (boot == 1);
    push_boot_bytes();
    arst_n <= 1'b0;
    repeat (2) @(posedge clk);
    check_reset_values();
    arst_n <= 1'b1;
    while (frames_seen < 3 * (boot + 1) || rx_cnt < BOOT_BYTES * (boot + 1)) begin
      @(posedge clk);
    end
    repeat (64) @(posedge clk); // Room for a stray strobe.
    if (rx_cnt != BOOT_BYTES * (boot + 1)) begin
      $display("[ERROR] %0t user_data_strb count: got %0d expected %0d",
               $time, rx_cnt - BOOT_BYTES * boot, BOOT_BYTES);
      end_errs++;
    end
    if (frame_err !== (boot == 1)) begin
      $display("[ERROR] %0t frame_err: got %b expected %b", $time, frame_err, boot == 1);
      end_errs++;
    end
    exp_q.delete();
  endtask

  tb_clk_gen u_clk_gen (.clk(clk));

  mmc_card_model u_card (
    .rst_n       (arst_n),
    .mmc_clk     (mmc_clk),
    .mmc_cmd     (mmc_cmd_o),
    .mmc_cmd_oen (mmc_cmd_oen),
    .corrupt_end (corrupt_end),
    .mmc_data    (mmc_data),
    .frame_cnt   (frame_cnt),
    .frame_bits  (frame_bits)
  );

  mmc_ro u_dut (
    .clk            (clk),
    .arst_n         (arst_n),
    .mmc_cmd_i      (mmc_cmd_i),
    .mmc_data_i     (mmc_data),
    .user_rdy       (user_rdy),
    .mmc_clk        (mmc_clk),
    .mmc_cmd_o      (mmc_cmd_o),
    .mmc_cmd_oen    (mmc_cmd_oen),
    .user_data_o    (user_data_o),
    .user_data_strb (user_data_strb),
    .frame_err      (frame_err)
  );

  // One LFSR bit per cycle, high about half the time.
  always @(posedge clk) begin
    rdy_lfsr = lfsr_step(rdy_lfsr);
    user_rdy <= rdy_lfsr[0];
  end

  always @(posedge clk) begin
    if (arst_n) begin
      if (user_data_strb && !last_rdy) begin
        $display("[ERROR] %0t user_data_strb: got 1 expected 0", $time); // Rdy was low.
        hs_errs++;
      end
      if (user_data_strb) begin
        rx_cnt++; // Every strobe, extras too.
        if (exp_q.size() == 0) begin
          $display("Extra strobe at %0t with no byte left to expect", $time);
          data_errs++;
        end else begin
          exp_byte = exp_q.pop_front();
          if (user_data_o !== exp_byte) begin
            $display("[ERROR] %0t user_data_o: got %02h expected %02h",
                     $time, user_data_o, exp_byte);
            data_errs++;
          end
        end
      end
      // Sticky flag, only the corrupted boot may raise it.
      if (frame_err && !err_seen && !corrupt_end) begin
        $display("[ERROR] %0t frame_err: got 1 expected 0", $time);
        flag_errs++;
      end
      if (!frame_err && err_seen) begin
        $display("[ERROR] %0t frame_err: got 0 expected 1", $time);
        flag_errs++;
      end
      if (frame_err) err_seen = 1'b1;
    end else begin
      err_seen = 1'b0;
    end
    if (int'(frame_cnt) != frames_seen) begin
      check_frame(frame_bits, frames_seen % 3);
      frames_seen++;
    end
    last_rdy = user_rdy;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles, the boots did not complete", WATCHDOG_CYCLES);
    $display("Regression failed");
    $finish;
  end

  initial begin
    arst_n = 1'b0;
    run_boot(0);
    run_boot(1); // End sample of block 1 corrupted.
    $display("Errors: data %0d, handshake %0d, frames %0d, frame_err %0d, end of boot %0d",
             data_errs, hs_errs, frame_errs, flag_errs, end_errs);
    if (data_errs + hs_errs + frame_errs + flag_errs + end_errs == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== mmc_ro.f ====
hdl/mmc_ro_pkg.sv
hdl/mmc_cmd_seq.sv
hdl/mmc_data_rx.sv
hdl/byte_fifo.sv
hdl/user_stream_out.sv
hdl/mmc_ro.sv
tests/tb_clk_gen.sv
tests/mmc_card_model.sv
tests/tb_mmc_ro.sv

// ==== run.sh ====
#!/bin/sh
# Builds the mmc_ro regression with Verilator and runs it.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module tb_mmc_ro -f mmc_ro.f > build.log 2>&1 \
  && ./obj_dir/Vtb_mmc_ro > sim.log 2>&1

grep -q "Regression passed" sim.log \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL, see build.log and sim.log"; exit 1; }
